// ==== files.f ====
+incdir+hw
hw/feat_mem_pkg.sv
hw/feat_vec_pkg.sv
hw/feature_sram.sv
hw/sram_read_arbiter.sv
hw/feature_sram_burst_reader.sv
hw/feature_dot_scorer.sv
hw/feature_match_top.sv
tb/feature_match_tb.sv

// ==== hw/feat_defs.svh ====
// Feature-matching engine constants for vector layout, SRAM geometry and tags
`ifndef FEAT_DEFS_SVH
`define FEAT_DEFS_SVH

// Vector and beat layout
`define FEAT_W          256
`define MEM_W           64
`define BEATS_PER_FEAT  (`FEAT_W / `MEM_W)

// Signed lanes as seen by the scorer
`define LANE_W          8
`define LANES           (`FEAT_W / `LANE_W)

// SRAM geometry and fixed read pipeline depth
`define ADDR_W          10
`define SRAM_DEPTH      1024
`define READ_LAT        2

// Command tag, plus one requester-id bit on the SRAM side
`define TAG_W           8
`define MEM_TAG_W       (`TAG_W + 1)

// 32 products of 8x8 signed lanes fit in 21 signed bits
`define SCORE_W         21

`endif

// ==== hw/feat_mem_pkg.sv ====
// Memory-side transfer types for the feature SRAM read and load ports
`default_nettype none
`include "feat_defs.svh"

package feat_mem_pkg;

  // One word read, tag carries the requester id in its top bit
  typedef struct packed {
    logic [`ADDR_W-1:0]    addr;
    logic [`MEM_TAG_W-1:0] tag;
  } mem_rd_req_t;

  // Read return, tag echoes the request
  typedef struct packed {
    logic [`MEM_W-1:0]     data;
    logic [`MEM_TAG_W-1:0] tag;
  } mem_rd_rsp_t;

  // Load port write from outside
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`MEM_W-1:0]  data;
  } mem_wr_req_t;

endpackage

`default_nettype wire

// ==== hw/feat_vec_pkg.sv ====
// Feature command, vector, reader output and score types
`default_nettype none
`include "feat_defs.svh"

package feat_vec_pkg;

  // Burst command into a reader
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [15:0]        beats;
    logic [`TAG_W-1:0]  tag;
  } feat_cmd_t;

  // One signed feature lane
  typedef logic signed [`LANE_W-1:0] lane_t;

  // Same 256 bits, written as beats by the reader, read as lanes by the scorer
  // Beat 0 and lane 0 both sit at the low end
  typedef union packed {
    logic [`BEATS_PER_FEAT-1:0][`MEM_W-1:0] beat;
    lane_t [`LANES-1:0]                     lane;
  } feat_vec_u;

  // Reader output
  typedef struct packed {
    feat_vec_u         vec;
    logic [`TAG_W-1:0] tag;
  } feat_out_t;

  // Dot product result, tag follows the query
  typedef struct packed {
    logic signed [`SCORE_W-1:0] value;
    logic [`TAG_W-1:0]          tag;
  } score_t;

endpackage

`default_nettype wire

// ==== hw/feature_dot_scorer.sv ====
// Joins a query and key vector and computes their signed lane dot product in two stages
`timescale 1ns/100ps
`default_nettype none
`include "feat_defs.svh"

module feature_dot_scorer (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire feat_vec_pkg::feat_out_t     query,
  input  wire logic                        query_valid,
  output logic                             query_ready,
  input  wire feat_vec_pkg::feat_out_t     key,
  input  wire logic                        key_valid,
  output logic                             key_ready,
  output feat_vec_pkg::score_t             score,
  output logic                             score_valid,
  input  wire logic                        score_ready
);

  localparam int HALF = `LANES / 2;

  logic                       pipe_en;
  logic                       s1_load;
  logic                       accept;
  logic                       s1_valid_q;
  logic signed [`SCORE_W-1:0] half_lo;
  logic signed [`SCORE_W-1:0] half_hi;
  logic signed [`SCORE_W-1:0] s1_lo_q;
  logic signed [`SCORE_W-1:0] s1_hi_q;
  logic [`TAG_W-1:0]          s1_tag_q;

  // ---------------------------------------------------------------------
  // Join and flow control
  // ---------------------------------------------------------------------
  // Output stall freezes both stages
  assign pipe_en     = !score_valid || score_ready;
  // Stage one takes a pair when empty or moving on
  assign s1_load     = !s1_valid_q || pipe_en;
  assign accept      = query_valid && key_valid && s1_load;
  // Each side ready only when its partner is there too
  assign query_ready = key_valid && s1_load;
  assign key_ready   = query_valid && s1_load;

  // ---------------------------------------------------------------------
  // Stage one, lane products reduced to two half sums
  // ---------------------------------------------------------------------
  always_comb begin
    half_lo = '0;
    half_hi = '0;
    for (int i = 0; i < HALF; i++) begin
      half_lo = half_lo + $signed(query.vec.lane[i]) * $signed(key.vec.lane[i]);
      half_hi = half_hi + $signed(query.vec.lane[i+HALF]) * $signed(key.vec.lane[i+HALF]);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_lo_q  <= half_lo;
      s1_hi_q  <= half_hi;
      s1_tag_q <= query.tag;
    end
  end

  // ---------------------------------------------------------------------
  // Stage two, final add
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (pipe_en && s1_valid_q) begin
      score.value <= s1_lo_q + s1_hi_q;
      score.tag   <= s1_tag_q;
    end
  end

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid_q  <= 1'b0;
      score_valid <= 1'b0;
    end else begin
      if (s1_load) begin
        s1_valid_q <= accept;
      end
      if (pipe_en) begin
        score_valid <= s1_valid_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/feature_match_top.sv ====
// Feature-matching engine top with SRAM, read arbiter, two burst readers and scorer
`timescale 1ns/100ps
`default_nettype none

module feature_match_top (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // Query command
  input  wire feat_vec_pkg::feat_cmd_t     q_cmd,
  input  wire logic                        q_cmd_valid,
  output logic                             q_cmd_ready,
  // Key command
  input  wire feat_vec_pkg::feat_cmd_t     k_cmd,
  input  wire logic                        k_cmd_valid,
  output logic                             k_cmd_ready,
  // Load port, never back-pressured
  input  wire feat_mem_pkg::mem_wr_req_t   load,
  input  wire logic                        load_valid,
  // Score out
  output feat_vec_pkg::score_t             score,
  output logic                             score_valid,
  input  wire logic                        score_ready
);

  // ---------------------------------------------------------------------
  // Interconnect, index 0 is the query reader, 1 the key reader
  // ---------------------------------------------------------------------
  feat_mem_pkg::mem_rd_req_t rd_req [2];
  logic [1:0]                rd_valid;
  logic [1:0]                rd_ready;
  feat_mem_pkg::mem_rd_rsp_t rd_rsp [2];
  logic [1:0]                rd_rsp_valid;
  feat_mem_pkg::mem_rd_req_t sram_rd;
  logic                      sram_rd_valid;
  logic                      sram_rd_ready;
  feat_mem_pkg::mem_rd_rsp_t sram_rsp;
  logic                      sram_rsp_valid;
  feat_vec_pkg::feat_out_t   q_feat;
  logic                      q_feat_valid;
  logic                      q_feat_ready;
  feat_vec_pkg::feat_out_t   k_feat;
  logic                      k_feat_valid;
  logic                      k_feat_ready;

  feature_sram u_sram (
    .clk       (clk),
    .rst       (rst),
    .wr        (load),
    .wr_valid  (load_valid),
    .rd        (sram_rd),
    .rd_valid  (sram_rd_valid),
    .rd_ready  (sram_rd_ready),
    .rsp       (sram_rsp),
    .rsp_valid (sram_rsp_valid)
  );

  sram_read_arbiter u_arb (
    .clk            (clk),
    .rst            (rst),
    .req            (rd_req),
    .req_valid      (rd_valid),
    .req_ready      (rd_ready),
    .sram_rd        (sram_rd),
    .sram_rd_valid  (sram_rd_valid),
    .sram_rd_ready  (sram_rd_ready),
    .sram_rsp       (sram_rsp),
    .sram_rsp_valid (sram_rsp_valid),
    .rsp            (rd_rsp),
    .rsp_valid      (rd_rsp_valid)
  );

  feature_sram_burst_reader query_reader (
    .clk          (clk),
    .rst          (rst),
    .cmd          (q_cmd),
    .cmd_valid    (q_cmd_valid),
    .cmd_ready    (q_cmd_ready),
    .mem_rd       (rd_req[0]),
    .mem_rd_valid (rd_valid[0]),
    .mem_rd_ready (rd_ready[0]),
    .mem_rsp      (rd_rsp[0]),
    .mem_rvalid   (rd_rsp_valid[0]),
    .feat         (q_feat),
    .feat_valid   (q_feat_valid),
    .feat_ready   (q_feat_ready)
  );

  feature_sram_burst_reader key_reader (
    .clk          (clk),
    .rst          (rst),
    .cmd          (k_cmd),
    .cmd_valid    (k_cmd_valid),
    .cmd_ready    (k_cmd_ready),
    .mem_rd       (rd_req[1]),
    .mem_rd_valid (rd_valid[1]),
    .mem_rd_ready (rd_ready[1]),
    .mem_rsp      (rd_rsp[1]),
    .mem_rvalid   (rd_rsp_valid[1]),
    .feat         (k_feat),
    .feat_valid   (k_feat_valid),
    .feat_ready   (k_feat_ready)
  );

  feature_dot_scorer u_scorer (
    .clk         (clk),
    .rst         (rst),
    .query       (q_feat),
    .query_valid (q_feat_valid),
    .query_ready (q_feat_ready),
    .key         (k_feat),
    .key_valid   (k_feat_valid),
    .key_ready   (k_feat_ready),
    .score       (score),
    .score_valid (score_valid),
    .score_ready (score_ready)
  );

endmodule

`default_nettype wire

// ==== hw/feature_sram.sv ====
// Single-port feature SRAM with load-port writes and a fixed-latency tagged read pipe
`timescale 1ns/100ps
`default_nettype none
`include "feat_defs.svh"

module feature_sram (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire feat_mem_pkg::mem_wr_req_t   wr,
  input  wire logic                        wr_valid,
  input  wire feat_mem_pkg::mem_rd_req_t   rd,
  input  wire logic                        rd_valid,
  output logic                             rd_ready,
  output feat_mem_pkg::mem_rd_rsp_t        rsp,
  output logic                             rsp_valid
);

  logic [`MEM_W-1:0]         mem [`SRAM_DEPTH];
  logic [`READ_LAT-1:0]      vld_pipe;
  feat_mem_pkg::mem_rd_rsp_t rsp_pipe [`READ_LAT];
  logic                      rd_fire;

  // Write owns the single port for the cycle
  assign rd_ready = !wr_valid;
  assign rd_fire  = rd_valid && rd_ready;

  // ---------------------------------------------------------------------
  // Valid pipe, the only control state here
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[`READ_LAT-2:0], rd_fire};
    end
  end

  // ---------------------------------------------------------------------
  // Array and data/tag pipe
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr.addr] <= wr.data;
    end
    // First stage samples the array, later stages just shift
    rsp_pipe[0].data <= mem[rd.addr];
    rsp_pipe[0].tag  <= rd.tag;
    for (int i = 1; i < `READ_LAT; i++) begin
      rsp_pipe[i] <= rsp_pipe[i-1];
    end
  end

  assign rsp       = rsp_pipe[`READ_LAT-1];
  assign rsp_valid = vld_pipe[`READ_LAT-1];

endmodule

`default_nettype wire

// ==== hw/feature_sram_burst_reader.sv ====
// Burst reader that fetches one feature vector word by word and holds it for output
`timescale 1ns/100ps
`default_nettype none
`include "feat_defs.svh"

module feature_sram_burst_reader (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // Burst command
  input  wire feat_vec_pkg::feat_cmd_t     cmd,
  input  wire logic                        cmd_valid,
  output logic                             cmd_ready,
  // Per-beat SRAM read
  output feat_mem_pkg::mem_rd_req_t        mem_rd,
  output logic                             mem_rd_valid,
  input  wire logic                        mem_rd_ready,
  input  wire feat_mem_pkg::mem_rd_rsp_t   mem_rsp,
  input  wire logic                        mem_rvalid,
  // Packed vector out
  output feat_vec_pkg::feat_out_t          feat,
  output logic                             feat_valid,
  input  wire logic                        feat_ready
);

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_OUT} state_t;

  localparam int          IDX_W     = $clog2(`BEATS_PER_FEAT);
  localparam logic [15:0] BEATS_MAX = 16'(`BEATS_PER_FEAT);

  state_t                  state_q;
  state_t                  state_d;
  logic [`ADDR_W-1:0]      addr_q;
  logic [15:0]             beats_q;
  logic [15:0]             issue_cnt_q;
  logic [15:0]             data_cnt_q;
  logic [`TAG_W-1:0]       tag_q;
  feat_vec_pkg::feat_vec_u buf_q;
  logic                    cmd_fire;
  logic                    mem_fire;
  logic                    out_fire;
  logic                    last_issue;
  logic                    last_data;

  // One burst at a time, new command only when idle
  assign cmd_ready  = (state_q == S_IDLE);
  assign cmd_fire   = cmd_valid && cmd_ready;
  assign mem_fire   = mem_rd_valid && mem_rd_ready;
  assign out_fire   = feat_valid && feat_ready;
  assign last_issue = mem_fire && (issue_cnt_q == beats_q - 16'd1);
  // Returns may have gaps, so completion counts mem_rvalid
  assign last_data  = mem_rvalid && (data_cnt_q == beats_q - 16'd1);

  // ---------------------------------------------------------------------
  // FSM
  // ---------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (cmd_fire)   state_d = S_ISSUE;
      S_ISSUE: if (last_issue) state_d = S_WAIT;
      S_WAIT:  if (last_data)  state_d = S_OUT;
      S_OUT:   if (out_fire)   state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_IDLE;
      issue_cnt_q <= '0;
      data_cnt_q  <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_fire) begin
        issue_cnt_q <= '0;
        data_cnt_q  <= '0;
      end else begin
        if (mem_fire) begin
          issue_cnt_q <= issue_cnt_q + 16'd1;
        end
        // Beats past the vector still count toward completion
        if (mem_rvalid) begin
          data_cnt_q <= data_cnt_q + 16'd1;
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Command latch, address walk and beat packing
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      addr_q  <= cmd.addr;
      // Zero beats runs as a single beat
      beats_q <= (cmd.beats == 16'd0) ? 16'd1 : cmd.beats;
      tag_q   <= cmd.tag;
      // Unread beats of a short burst stay zero
      buf_q   <= '0;
    end else begin
      if (mem_fire) begin
        addr_q <= addr_q + 1'b1;
      end
      // Little-endian, beat n lands at bits n*64 upward
      if (mem_rvalid && (data_cnt_q < BEATS_MAX)) begin
        buf_q.beat[data_cnt_q[IDX_W-1:0]] <= mem_rsp.data;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Outputs
  // ---------------------------------------------------------------------
  assign mem_rd_valid = (state_q == S_ISSUE);
  // Vector held steady in S_OUT until taken
  assign feat_valid   = (state_q == S_OUT);

  always_comb begin
    mem_rd.addr = addr_q;
    // Top bit is the requester id, filled in by the arbiter
    mem_rd.tag  = {1'b0, tag_q};
    feat.vec    = buf_q;
    feat.tag    = tag_q;
  end

endmodule

`default_nettype wire

// ==== hw/sram_read_arbiter.sv ====
// Round-robin arbiter of two readers onto the SRAM read port, with response routing
`timescale 1ns/100ps
`default_nettype none
`include "feat_defs.svh"

module sram_read_arbiter (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // Requester side
  input  wire feat_mem_pkg::mem_rd_req_t   req [2],
  input  wire logic [1:0]                  req_valid,
  output logic [1:0]                       req_ready,
  // SRAM side
  output feat_mem_pkg::mem_rd_req_t        sram_rd,
  output logic                             sram_rd_valid,
  input  wire logic                        sram_rd_ready,
  input  wire feat_mem_pkg::mem_rd_rsp_t   sram_rsp,
  input  wire logic                        sram_rsp_valid,
  // Routed responses
  output feat_mem_pkg::mem_rd_rsp_t        rsp [2],
  output logic [1:0]                       rsp_valid
);

  // Priority pointer, names the requester that wins a tie
  logic ptr_q;
  logic gnt;
  logic rsp_id;

  // ---------------------------------------------------------------------
  // Request path, purely combinational
  // ---------------------------------------------------------------------
  // Pointer holder wins if requesting, else the other one
  assign gnt           = req_valid[ptr_q] ? ptr_q : !ptr_q;
  assign sram_rd_valid = |req_valid;
  assign req_ready[0]  = sram_rd_ready && !gnt;
  assign req_ready[1]  = sram_rd_ready && gnt;

  always_comb begin
    sram_rd.addr = req[gnt].addr;
    // Requester id replaces the top tag bit
    sram_rd.tag  = {gnt, req[gnt].tag[`TAG_W-1:0]};
  end

  // Rotate after every granted beat so the loser goes next
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= 1'b0;
    end else if (sram_rd_valid && sram_rd_ready) begin
      ptr_q <= !gnt;
    end
  end

  // ---------------------------------------------------------------------
  // Response path
  // ---------------------------------------------------------------------
  assign rsp_id       = sram_rsp.tag[`MEM_TAG_W-1];
  assign rsp_valid[0] = sram_rsp_valid && !rsp_id;
  assign rsp_valid[1] = sram_rsp_valid && rsp_id;

  // Both see the data, id bit stripped
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rsp[i].data = sram_rsp.data;
      rsp[i].tag  = {1'b0, sram_rsp.tag[`TAG_W-1:0]};
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the feature-matching engine testbench with Verilator
set -e

cd "$(dirname "$0")"

mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
  -f files.f \
  --top-module feature_match_tb \
  -Mdir build/obj_dir \
  -o feature_match_sim

./build/obj_dir/feature_match_sim | tee build/sim.log

if grep -q "Finished with no errors" build/sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb/feature_match_tb.sv ====
// Testbench for the feature-matching engine with memory mirror, score model and checks
`timescale 1ns/100ps
`default_nettype none
`include "feat_defs.svh"

module feature_match_tb;

  localparam int          RESET_CYCLES = 10;
  localparam int          CMD_LIMIT    = 500;
  localparam int          DRAIN_LIMIT  = 5000;
  localparam logic [31:0] SEED         = 32'h3890784e;

  logic                        clk;
  logic                        rst;
  feat_vec_pkg::feat_cmd_t     q_cmd;
  logic                        q_cmd_valid;
  logic                        q_cmd_ready;
  feat_vec_pkg::feat_cmd_t     k_cmd;
  logic                        k_cmd_valid;
  logic                        k_cmd_ready;
  feat_mem_pkg::mem_wr_req_t   load;
  logic                        load_valid;
  feat_vec_pkg::score_t        score;
  logic                        score_valid;
  logic                        score_ready;

  // Mirror of every load, and scores still owed by the DUT
  logic [`MEM_W-1:0]           mem_model [`SRAM_DEPTH];
  feat_vec_pkg::score_t        exp_q [$];
  int                          err_cnt;
  int                          check_cnt;
  int                          test_cnt;
  logic                        timed_out;
  logic                        held_valid;
  feat_vec_pkg::score_t        held_score;

  feature_match_top UUT (
    .clk         (clk),
    .rst         (rst),
    .q_cmd       (q_cmd),
    .q_cmd_valid (q_cmd_valid),
    .q_cmd_ready (q_cmd_ready),
    .k_cmd       (k_cmd),
    .k_cmd_valid (k_cmd_valid),
    .k_cmd_ready (k_cmd_ready),
    .load        (load),
    .load_valid  (load_valid),
    .score       (score),
    .score_valid (score_valid),
    .score_ready (score_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  // Beat b fills lanes 8b..8b+7, beats past a short burst stay zero
  function automatic logic [`FEAT_W-1:0] fetch_vec(input logic [`ADDR_W-1:0] addr,
                                                   input logic [15:0] beats);
    logic [`FEAT_W-1:0] v;
    int                 n;
    v = '0;
    n = (beats == 16'd0) ? 1 : int'(beats);
    for (int b = 0; b < `BEATS_PER_FEAT; b++) begin
      // Word address wraps at the top of the SRAM
      if (b < n) v[b*`MEM_W +: `MEM_W] = mem_model[`ADDR_W'(int'(addr) + b)];
    end
    return v;
  endfunction

  // Signed sum of lane products
  function automatic logic signed [`SCORE_W-1:0] dot_lanes(input logic [`FEAT_W-1:0] a,
                                                           input logic [`FEAT_W-1:0] b);
    int sum;
    int pa;
    int pb;
    sum = 0;
    for (int i = 0; i < `LANES; i++) begin
      pa  = int'($signed(a[i*`LANE_W +: `LANE_W]));
      pb  = int'($signed(b[i*`LANE_W +: `LANE_W]));
      sum = sum + pa * pb;
    end
    return `SCORE_W'(sum);
  endfunction

  // ----------------------------------------------------------------------
  // Score monitor
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (!rst && score_valid && score_ready) begin
      check_cnt++;
      assert (exp_q.size() > 0) else begin
        $display("[ERROR] %0t: score tag %0h arrived with no job outstanding",
                 $time, score.tag);
        err_cnt++;
      end
      if (exp_q.size() > 0) begin
        assert (score == exp_q[0]) else begin
          $display("[ERROR] %0t: score %0d tag %0h, expected %0d tag %0h", $time,
                   score.value, score.tag, exp_q[0].value, exp_q[0].tag);
          err_cnt++;
        end
        void'(exp_q.pop_front());
      end
    end
    // Stalled output must hold still
    if (!rst && held_valid) begin
      check_cnt++;
      assert (score_valid && score == held_score) else begin
        $display("[ERROR] %0t: score changed or dropped while stalled", $time);
        err_cnt++;
      end
    end
    held_valid = !rst && score_valid && !score_ready;
    held_score = score;
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  task automatic write_word(input logic [`ADDR_W-1:0] addr, input logic [`MEM_W-1:0] data);
    feat_mem_pkg::mem_wr_req_t w;
    w.addr = addr;
    w.data = data;
    @(posedge clk);
    load       <= w;
    load_valid <= 1'b1;
    mem_model[addr] = data;
  endtask

  task automatic idle_load();
    @(posedge clk);
    load_valid <= 1'b0;
  endtask

  // Issue a query and key command, the query tag rides on the score
  task automatic send_job(input logic [`ADDR_W-1:0] qa, input logic [15:0] qb,
                          input logic [`ADDR_W-1:0] ka, input logic [15:0] kb,
                          input logic [`TAG_W-1:0] tag);
    feat_vec_pkg::feat_cmd_t qc;
    feat_vec_pkg::feat_cmd_t kc;
    feat_vec_pkg::score_t    exp;
    logic                    q_done;
    logic                    k_done;
    int                      cnt;
    if (!timed_out) begin
      qc.addr  = qa;
      qc.beats = qb;
      qc.tag   = tag;
      kc.addr  = ka;
      kc.beats = kb;
      // Different key tag, so a wrong tag source shows up
      kc.tag   = ~tag;
      exp.value = dot_lanes(fetch_vec(qa, qb), fetch_vec(ka, kb));
      exp.tag   = tag;
      exp_q.push_back(exp);
      @(posedge clk);
      q_cmd       <= qc;
      q_cmd_valid <= 1'b1;
      k_cmd       <= kc;
      k_cmd_valid <= 1'b1;
      q_done = 1'b0;
      k_done = 1'b0;
      cnt    = 0;
      while (!(q_done && k_done) && !timed_out) begin
        @(posedge clk);
        if (!q_done && q_cmd_ready) begin
          q_done = 1'b1;
          q_cmd_valid <= 1'b0;
        end
        if (!k_done && k_cmd_ready) begin
          k_done = 1'b1;
          k_cmd_valid <= 1'b0;
        end
        cnt++;
        if (!(q_done && k_done) && cnt >= CMD_LIMIT) begin
          $display("Timeout: commands of job tag %0h not accepted in %0d cycles", tag, cnt);
          timed_out = 1'b1;
        end
      end
    end
  endtask

  task automatic wait_drained(input string what);
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && !timed_out) begin
      @(posedge clk);
      cnt++;
      if (cnt >= DRAIN_LIMIT) begin
        $display("Timeout: %0d scores of %s missing after %0d cycles",
                 exp_q.size(), what, cnt);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic check_idle(input string when);
    check_cnt++;
    assert (!score_valid && q_cmd_ready && k_cmd_ready) else begin
      $display("[ERROR] %0t: %s score_valid=%b q_cmd_ready=%b k_cmd_ready=%b", $time,
               when, score_valid, q_cmd_ready, k_cmd_ready);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    $display("Test %s done, %0d errors", name, err_cnt - errs_before);
  endtask

  function automatic logic [`ADDR_W-1:0] rand_addr();
    return `ADDR_W'($urandom_range(0, `SRAM_DEPTH - 1));
  endfunction

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_reset_state();
    int e0;
    e0 = err_cnt;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      // State is unknown before the first reset edge
      if (i > 0) check_idle("during reset");
    end
    rst <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      check_idle("after reset");
    end
    finish_test("reset_state", e0);
  endtask

  task automatic test_single_job();
    int e0;
    e0 = err_cnt;
    for (int a = 0; a < `SRAM_DEPTH; a++) begin
      write_word(`ADDR_W'(a), {$urandom, $urandom});
    end
    idle_load();
    send_job(rand_addr(), 16'd4, rand_addr(), 16'd4, 8'h5a);
    wait_drained("single job");
    finish_test("single_job", e0);
  endtask

  task automatic test_contention();
    int e0;
    e0 = err_cnt;
    for (int j = 0; j < 20; j++) begin
      send_job(rand_addr(), 16'd4, rand_addr(), 16'd4, `TAG_W'(j));
    end
    wait_drained("contention");
    finish_test("contention", e0);
  endtask

  task automatic test_burst_length();
    int e0;
    e0 = err_cnt;
    send_job(rand_addr(), 16'd2, rand_addr(), 16'd2, 8'h21);
    send_job(rand_addr(), 16'd0, rand_addr(), 16'd0, 8'h22);
    send_job(rand_addr(), 16'd6, rand_addr(), 16'd6, 8'h23);
    send_job(rand_addr(), 16'd2, rand_addr(), 16'd6, 8'h24);
    send_job(rand_addr(), 16'd0, rand_addr(), 16'd4, 8'h25);
    wait_drained("burst length");
    finish_test("burst_length", e0);
  endtask

  task automatic test_back_pressure();
    int   e0;
    int   cnt;
    logic busy;
    e0   = err_cnt;
    busy = 1'b1;
    fork
      begin
        for (int j = 0; j < 20; j++) begin
          send_job(rand_addr(), 16'd4, rand_addr(), 16'd4, `TAG_W'(8'h80 + j));
        end
        wait_drained("back-pressure");
        busy = 1'b0;
      end
      begin
        cnt = 0;
        while (busy && cnt < 2 * DRAIN_LIMIT) begin
          @(posedge clk);
          score_ready <= 1'($urandom_range(0, 1));
          cnt++;
        end
        if (busy) begin
          $display("Timeout: score_ready toggling ran %0d cycles without drain", cnt);
          timed_out = 1'b1;
        end
      end
    join
    score_ready <= 1'b1;
    finish_test("back_pressure", e0);
  endtask

  // Loads go to 800..839 while jobs read below 404
  task automatic test_load_during_reads();
    int e0;
    e0 = err_cnt;
    fork
      begin
        for (int j = 0; j < 8; j++) begin
          send_job(`ADDR_W'($urandom_range(0, 400)), 16'd4,
                   `ADDR_W'($urandom_range(0, 400)), 16'd4, `TAG_W'(8'hc0 + j));
        end
      end
      begin
        for (int a = 800; a < 840; a++) begin
          write_word(`ADDR_W'(a), {$urandom, $urandom});
          if ($urandom_range(0, 3) == 0) idle_load();
        end
        idle_load();
      end
    join
    wait_drained("reads during loads");
    // Later jobs read only freshly written words
    for (int j = 0; j < 4; j++) begin
      send_job(`ADDR_W'(800 + 8 * j), 16'd4, `ADDR_W'(832 - 8 * j), 16'd4, `TAG_W'(8'he0 + j));
    end
    wait_drained("reads of new words");
    finish_test("load_during_reads", e0);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    err_cnt     = 0;
    check_cnt   = 0;
    test_cnt    = 0;
    timed_out   = 1'b0;
    held_valid  = 1'b0;
    rst         = 1'b1;
    q_cmd       = '0;
    q_cmd_valid = 1'b0;
    k_cmd       = '0;
    k_cmd_valid = 1'b0;
    load        = '0;
    load_valid  = 1'b0;
    score_ready = 1'b1;
    test_reset_state();
    test_single_job();
    test_contention();
    test_burst_length();
    test_back_pressure();
    test_load_during_reads();
    $display("Tests: %0d, checks: %0d, errors: %0d, timeout: %0b",
             test_cnt, check_cnt, err_cnt, timed_out);
    if (err_cnt == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
